//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,  // ns
  parameter int RESET_CYCLES = 4
) (
  output logic pclk,
  output logic rst
);

  initial begin
    pclk = 1'b0;
    forever #(PERIOD / 2) pclk = ~pclk;
  end

  // released on a rising edge, so the dut sees whole reset cycles
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge pclk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////
// phase script
////////////////////////////////////////

localparam int M_IDLE       = 0;
localparam int M_SHIFT_DOWN = 3;
localparam int M_LAST       = 7;  // shift_right_center

localparam int F_TOP    = 317;
localparam int F_BOTTOM = 617;
localparam int F_LEFT   = 361;
localparam int F_RIGHT  = 661;

// edge order is top, bottom, left, right
function automatic int start_pos(input int e);
  int s [4];
  s = '{F_TOP + 1, F_BOTTOM - 1, F_LEFT + 1, F_RIGHT - 1};  // one pixel inside the field
  return s[e];
endfunction

// +1 moves to larger coordinates, -1 to smaller, 0 holds
function automatic int script_dir(input int ph, input int e);
  int d [4];
  case (ph)
    1:       d = '{1, -1, 1, -1};    // close_in
    2:       d = '{-1, -1, 1, 1};    // shift_right_up
    3:       d = '{1, 1, 0, 0};      // shift_down
    4:       d = '{-1, -1, -1, -1};  // shift_left_up
    5:       d = '{0, -1, 0, -1};    // shrink
    6:       d = '{1, 1, 0, 0};      // shift_down_mid
    7:       d = '{0, 0, 1, 1};      // shift_right_center
    default: d = '{0, 0, 0, 0};
  endcase
  return d[e];
endfunction

function automatic int script_target(input int ph);
  int t [8];
  t = '{0, 442, 661, 617, 317, 401, 447, 491};
  return t[ph];
endfunction

function automatic int script_watch(input int ph);
  int w [8];
  w = '{0, 0, 3, 1, 0, 3, 0, 2};
  return w[ph];
endfunction

function automatic bit script_fast(input int ph);
  bit f [8];
  f = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
  return f[ph];
endfunction

function automatic bit edge_reached(input int dir, input int pos, input int target);
  bit r;
  if (dir > 0) begin
    r = (pos >= target);
  end else if (dir < 0) begin
    r = (pos <= target);
  end else begin
    r = 1'b0;  // a holding edge never ends a phase
  end
  return r;
endfunction

// wall is the field minus the open hole
function automatic bit wall_pixel(input int h, input int v, input int top, input int bottom,
                                  input int left, input int right);
  bit in_field;
  in_field = (h >= F_LEFT) && (h <= F_RIGHT) && (v >= F_TOP) && (v <= F_BOTTOM);
  return in_field && ((v <= top) || (v >= bottom) || (h >= right) || (h <= left));
endfunction

`endif

//--- bench/tb_laser_square_obstacle.sv
`timescale 1ns/1ns
`default_nettype none

module tb_laser_square_obstacle;

  `include "tb_model.svh"

  localparam int STEP_TICKS = 3;
  localparam int HOLD_TICKS = 5;
  localparam logic [3:0] LEVEL = 4'd3;
  localparam int SCRIPT_CYCLES = 3200;  // one full script with holds rounded up
  localparam int TIMEOUT_CYCLES = 3 * SCRIPT_CYCLES + 2400;

  logic        pclk;
  logic        rst;
  logic [11:0] hcount;
  logic [11:0] vcount;
  logic [11:0] rgb_in;
  logic        done_control;
  logic        play_selected;
  logic [3:0]  selected;
  logic        menu_on;
  wire  [11:0] rgb_out;
  wire  [11:0] obstacle_x;
  wire  [11:0] obstacle_y;
  wire         working;
  wire         done;

  int          m_phase;
  int          m_step_cnt;
  int          m_hold_cnt;
  int          m_pos [4];
  bit          m_done;
  bit          model_valid;
  logic [11:0] exp_rgb;
  logic [11:0] exp_x;
  logic [11:0] exp_y;
  bit   [31:0] rnd = 32'hf48b0f14;
  int          cycle_cnt;
  int          checks;
  int          errors;
  int          done_seen;
  bit          timed_out;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) clock_gen_i (.pclk(pclk), .rst(rst));

  laser_square_obstacle #(
    .STEP_TICKS(STEP_TICKS),
    .HOLD_TICKS(HOLD_TICKS)
  ) laser_square_obstacle_i (.*);

  function automatic bit [31:0] next_rand(input bit [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // registered output one cycle after the pixel as {rgb, x, y}
  function automatic logic [35:0] expected_pixel(input int h, input int v, input logic [11:0] rgb,
                                                 input bit active);
    if (active && wall_pixel(h, v, m_pos[0], m_pos[1], m_pos[2], m_pos[3])) begin
      return {12'hfff, 12'(h), 12'(v)};
    end else begin
      return {rgb, 24'h0};
    end
  endfunction

  task automatic check_value(input string name, input logic [11:0] got, input logic [11:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk);
  endtask

  task automatic start_level(input logic [3:0] sel, input logic play);
    @(posedge pclk);
    selected      <= sel;
    play_selected <= play;
    done_control  <= 1'b1;
    @(posedge pclk);
    done_control  <= 1'b0;
  endtask

  task automatic wait_for_done();
    @(negedge pclk);
    while (done !== 1'b1) @(negedge pclk);
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, done pulses %0d", checks, errors, done_seen);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // random pixels mostly inside the field
  ////////////////////////////////////////

  always @(posedge pclk) begin
    rnd = next_rand(rnd);
    hcount <= 12'(F_LEFT - 8 + int'((rnd >> 8) % 32'd317));
    rnd = next_rand(rnd);
    vcount <= 12'(F_TOP - 8 + int'((rnd >> 8) % 32'd317));
    rgb_in <= rnd[23:12];
  end

  ////////////////////////////////////////
  // model
  ////////////////////////////////////////

  always @(posedge pclk) begin
    int w;
    int nxt;
    bit hit;
    bit step_now;
    bit done_nxt;
    if (rst) begin
      m_phase    = M_IDLE;
      m_step_cnt = 0;
      m_hold_cnt = 0;
      m_pos      = '{0, 0, 0, 0};
      m_done     = 1'b0;
      {exp_rgb, exp_x, exp_y} = 36'h0;
    end else begin
      {exp_rgb, exp_x, exp_y} = expected_pixel(int'(hcount), int'(vcount), rgb_in,
                                               m_phase != M_IDLE);
      w        = script_watch(m_phase);
      hit      = (m_phase != M_IDLE) &&
                 edge_reached(script_dir(m_phase, w), m_pos[w], script_target(m_phase));
      step_now = (m_phase != M_IDLE) && !hit &&
                 (m_step_cnt == (script_fast(m_phase) ? STEP_TICKS / 2 : STEP_TICKS));
      nxt      = m_phase;
      done_nxt = 1'b0;
      if (m_phase == M_IDLE) begin
        if (done_control && selected == LEVEL && play_selected) nxt = 1;
      end else if (menu_on || !play_selected) begin
        nxt = M_IDLE;  // abort without done
      end else if (hit && m_hold_cnt == HOLD_TICKS) begin
        nxt      = (m_phase == M_LAST) ? M_IDLE : m_phase + 1;
        done_nxt = (nxt == M_IDLE);
      end
      if (nxt != m_phase) begin
        m_step_cnt = 0;  // both timers restart on phase entry
        m_hold_cnt = 0;
      end else if (hit) begin
        m_hold_cnt++;
      end else if (step_now) begin
        m_step_cnt = 0;
      end else if (m_phase != M_IDLE) begin
        m_step_cnt++;
      end
      for (int e = 0; e < 4; e++) begin
        if (m_phase == M_IDLE && done_control) begin
          m_pos[e] = start_pos(e);
        end else if (step_now) begin
          m_pos[e] += script_dir(m_phase, e);
        end
      end
      m_phase = nxt;
      m_done  = done_nxt;
    end
    model_valid = 1'b1;
  end

  ////////////////////////////////////////
  // compare and timeout
  ////////////////////////////////////////

  always @(negedge pclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      timed_out = 1'b1;
      finish_run();
    end else if (model_valid) begin
      check_value("rgb_out", rgb_out, exp_rgb);
      check_value("obstacle_x", obstacle_x, exp_x);
      check_value("obstacle_y", obstacle_y, exp_y);
      check_value("working", 12'(working), 12'(m_phase != M_IDLE));
      check_value("done", 12'(done), 12'(m_done));
      if (done === 1'b1) done_seen++;
    end
  end

  initial begin
    int done_before;
    hcount        = '0;
    vcount        = '0;
    rgb_in        = '0;
    done_control  = 1'b0;
    play_selected = 1'b0;
    selected      = '0;
    menu_on       = 1'b0;
    @(negedge rst);
    wait_cycles(20);
    start_level(4'd5, 1'b1);  // wrong level
    wait_cycles(20);
    start_level(LEVEL, 1'b0);  // play not selected
    wait_cycles(20);
    repeat (2) begin
      start_level(LEVEL, 1'b1);
      wait_for_done();
      wait_cycles(20);
    end
    start_level(LEVEL, 1'b1);
    while (m_phase != M_SHIFT_DOWN) @(negedge pclk);
    wait_cycles(100);
    done_before = done_seen;
    menu_on <= 1'b1;
    wait_cycles(3);
    menu_on <= 1'b0;
    @(negedge pclk);
    if (working !== 1'b0) begin
      errors++;
      $display("working stayed high after menu_on was raised");
    end
    wait_cycles(50);
    if (done_seen != done_before) begin
      errors++;
      $display("done pulsed after the run was aborted");
    end
    if (done_seen != 2) begin
      errors++;
      $display("done pulsed %0d times, two full runs expect 2", done_seen);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

TOP=tb_laser_square_obstacle
LOG=sim.log

verilator --binary --timing -f src.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0

//--- source/hole_edge.sv
`timescale 1ns/1ns
`default_nettype none

module hole_edge
  import obstacle_pkg::*;
#(
  parameter edge_t EDGE = EDGE_TOP
) (
  input wire    pclk,
  input wire    rst,
  hole_if.edges hole
);

  // one pixel inside the field border
  localparam coord_t START_POS =
    (EDGE == EDGE_TOP)    ? FIELD_TOP + 12'd1 :
    (EDGE == EDGE_BOTTOM) ? FIELD_BOTTOM - 12'd1 :
    (EDGE == EDGE_LEFT)   ? FIELD_LEFT + 12'd1 :
                            FIELD_RIGHT - 12'd1;

  coord_t pos;
  step_t  dir;
  logic   reached;

  assign dir = hole.dir[EDGE];

  always_ff @(posedge pclk) begin
    if (rst) begin
      pos <= '0;
    end else if (hole.load) begin
      pos <= START_POS;
    end else if (hole.step) begin
      case (dir)
        STEP_INC: pos <= pos + 1'b1;
        STEP_DEC: pos <= pos - 1'b1;
        default:  pos <= pos;
      endcase
    end
  end

  // a holding edge never counts as reached
  always_comb begin
    case (dir)
      STEP_INC: reached = (pos >= hole.target);
      STEP_DEC: reached = (pos <= hole.target);
      default:  reached = 1'b0;
    endcase
  end

  assign hole.pos[EDGE]     = pos;
  assign hole.reached[EDGE] = reached;

endmodule

`default_nettype wire

//--- source/hole_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hole_if
  import obstacle_pkg::*;
();

  logic   load;                  // edges take their start values
  logic   step;                  // one-cycle move strobe
  step_t  dir [NUM_EDGES];       // per-edge move direction
  coord_t target;                // compare value of the current phase
  logic   active;                // phase is not idle
  coord_t pos [NUM_EDGES];       // current edge positions
  logic   reached [NUM_EDGES];   // edge is at or past target

  modport seq (output load, step, dir, target, active, input reached);

  // seen by each hole edge
  modport edges (input load, step, dir, target, output pos, reached);

  modport render (input pos, active);

endinterface

`default_nettype wire

//--- source/laser_square_obstacle.sv
`timescale 1ns/1ns
`default_nettype none

module laser_square_obstacle
  import obstacle_pkg::*;
#(
  parameter int STEP_TICKS = 3200000,  // slow step period minus one
  parameter int HOLD_TICKS = 32000000  // pause between phases
) (
  input wire         pclk,
  input wire         rst,
  input wire coord_t hcount,
  input wire coord_t vcount,
  input wire rgb_t   rgb_in,
  input wire         done_control,
  input wire         play_selected,
  input wire [3:0]   selected,
  input wire         menu_on,
  output wire rgb_t   rgb_out,
  output wire coord_t obstacle_x,
  output wire coord_t obstacle_y,
  output wire        working,
  output wire        done
);

  hole_if hole ();

  phase_sequencer #(
    .STEP_TICKS(STEP_TICKS),
    .HOLD_TICKS(HOLD_TICKS)
  ) phase_sequencer_i (
    .pclk          (pclk),
    .rst           (rst),
    .done_control  (done_control),
    .play_selected (play_selected),
    .selected      (selected),
    .menu_on       (menu_on),
    .working       (working),
    .done          (done),
    .hole          (hole.seq)
  );

  // one instance per hole edge
  for (genvar i = 0; i < NUM_EDGES; i++) begin : g_edge
    hole_edge #(
      .EDGE(edge_t'(i))
    ) hole_edge_i (
      .pclk (pclk),
      .rst  (rst),
      .hole (hole.edges)
    );
  end

  wall_renderer wall_renderer_i (
    .pclk       (pclk),
    .rst        (rst),
    .hcount     (hcount),
    .vcount     (vcount),
    .rgb_in     (rgb_in),
    .hole       (hole.render),
    .rgb_out    (rgb_out),
    .obstacle_x (obstacle_x),
    .obstacle_y (obstacle_y)
  );

endmodule

`default_nettype wire

//--- source/obstacle_pkg.sv
`default_nettype none

package obstacle_pkg;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [11:0] coord_t;  // pixel coordinate on screen
  typedef logic [11:0] rgb_t;    // 4 bits per channel

  // edges of the hole and index of the per-edge arrays
  typedef enum logic [1:0] {
    EDGE_TOP,
    EDGE_BOTTOM,
    EDGE_LEFT,
    EDGE_RIGHT
  } edge_t;

  localparam int NUM_EDGES = 4;

  typedef enum logic [1:0] {
    STEP_HOLD,
    STEP_INC,  // towards larger coordinates
    STEP_DEC
  } step_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CLOSE_IN,
    PH_SHIFT_RIGHT_UP,
    PH_SHIFT_DOWN,
    PH_SHIFT_LEFT_UP,
    PH_SHRINK,
    PH_SHIFT_DOWN_MID,
    PH_SHIFT_RIGHT_CENTER
  } phase_t;

  ////////////////////////////////////////
  // game field
  ////////////////////////////////////////

  localparam coord_t FIELD_TOP    = 12'd317;
  localparam coord_t FIELD_BOTTOM = 12'd617;
  localparam coord_t FIELD_LEFT   = 12'd361;
  localparam coord_t FIELD_RIGHT  = 12'd661;

  localparam rgb_t WALL_RGB = 12'hfff;  // white

  localparam logic [3:0] LEVEL_CODE = 4'd3;  // menu selection for this obstacle

endpackage

`default_nettype wire

//--- source/phase_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module phase_sequencer
  import obstacle_pkg::*;
#(
  parameter int STEP_TICKS = 3200000,
  parameter int HOLD_TICKS = 32000000
) (
  input wire        pclk,
  input wire        rst,
  input wire        done_control,
  input wire        play_selected,
  input wire  [3:0] selected,
  input wire        menu_on,
  output logic      working,
  output logic      done,
  hole_if.seq       hole
);

  localparam int STEP_W = $clog2(STEP_TICKS + 1);
  localparam int HOLD_W = $clog2(HOLD_TICKS + 1);

  localparam logic [STEP_W-1:0] SLOW_LIMIT = STEP_W'(STEP_TICKS);
  localparam logic [STEP_W-1:0] FAST_LIMIT = STEP_W'(STEP_TICKS / 2);
  localparam logic [HOLD_W-1:0] HOLD_LIMIT = HOLD_W'(HOLD_TICKS);

  phase_t            phase, phase_next, phase_after;
  logic [STEP_W-1:0] step_cnt, step_limit;
  logic [HOLD_W-1:0] hold_cnt;
  step_t             dir [NUM_EDGES];
  coord_t            target;
  edge_t             watch;
  logic              fast, watch_reached, hold_done, abort, start, done_next;

  ////////////////////////////////////////
  // phase script
  ////////////////////////////////////////

  // dir order is top, bottom, left, right
  always_comb begin
    dir         = '{default: STEP_HOLD};
    target      = FIELD_TOP;
    watch       = EDGE_TOP;
    fast        = 1'b0;
    phase_after = PH_IDLE;
    case (phase)
      PH_CLOSE_IN: begin
        dir         = '{STEP_INC, STEP_DEC, STEP_INC, STEP_DEC};
        target      = FIELD_TOP + 12'd125;
        phase_after = PH_SHIFT_RIGHT_UP;
      end
      PH_SHIFT_RIGHT_UP: begin
        dir         = '{STEP_DEC, STEP_DEC, STEP_INC, STEP_INC};
        target      = FIELD_RIGHT;
        watch       = EDGE_RIGHT;
        phase_after = PH_SHIFT_DOWN;
      end
      PH_SHIFT_DOWN: begin
        dir         = '{STEP_INC, STEP_INC, STEP_HOLD, STEP_HOLD};
        target      = FIELD_BOTTOM;
        watch       = EDGE_BOTTOM;
        phase_after = PH_SHIFT_LEFT_UP;
      end
      PH_SHIFT_LEFT_UP: begin
        dir         = '{STEP_DEC, STEP_DEC, STEP_DEC, STEP_DEC};
        fast        = 1'b1;
        phase_after = PH_SHRINK;
      end
      PH_SHRINK: begin
        dir         = '{STEP_HOLD, STEP_DEC, STEP_HOLD, STEP_DEC};
        target      = FIELD_LEFT + 12'd40;
        watch       = EDGE_RIGHT;
        phase_after = PH_SHIFT_DOWN_MID;
      end
      PH_SHIFT_DOWN_MID: begin
        dir         = '{STEP_INC, STEP_INC, STEP_HOLD, STEP_HOLD};
        target      = FIELD_TOP + 12'd130;
        fast        = 1'b1;
        phase_after = PH_SHIFT_RIGHT_CENTER;
      end
      PH_SHIFT_RIGHT_CENTER: begin
        dir    = '{STEP_HOLD, STEP_HOLD, STEP_INC, STEP_INC};
        target = FIELD_LEFT + 12'd130;
        watch  = EDGE_LEFT;
        fast   = 1'b1;  // last phase returns to idle
      end
      default: ;  // nothing moves in idle
    endcase
  end

  ////////////////////////////////////////
  // phase control
  ////////////////////////////////////////

  assign abort         = menu_on || !play_selected;
  assign start         = done_control && (selected == LEVEL_CODE) && play_selected;
  assign watch_reached = hole.reached[watch];
  assign step_limit    = fast ? FAST_LIMIT : SLOW_LIMIT;
  assign hold_done     = watch_reached && (hold_cnt == HOLD_LIMIT);

  always_comb begin
    phase_next = phase;
    done_next  = 1'b0;
    if (phase == PH_IDLE) begin
      if (start) begin
        phase_next = PH_CLOSE_IN;
      end
    end else if (abort) begin
      phase_next = PH_IDLE;  // leave without done
    end else if (hold_done) begin
      phase_next = phase_after;
      done_next  = (phase_after == PH_IDLE);
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      phase    <= PH_IDLE;
      step_cnt <= '0;
      hold_cnt <= '0;
      done     <= 1'b0;
    end else begin
      phase <= phase_next;
      done  <= done_next;
      if (phase_next != phase) begin
        step_cnt <= '0;  // fresh timers on every phase entry
        hold_cnt <= '0;
      end else if (phase != PH_IDLE) begin
        if (watch_reached) begin
          hold_cnt <= hold_cnt + 1'b1;
        end else if (hole.step) begin
          step_cnt <= '0;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  assign working     = (phase != PH_IDLE);
  assign hole.active = working;
  assign hole.load   = (phase == PH_IDLE) && done_control;
  assign hole.step   = working && !watch_reached && (step_cnt == step_limit);
  assign hole.dir    = dir;
  assign hole.target = target;

endmodule

`default_nettype wire

//--- source/wall_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module wall_renderer
  import obstacle_pkg::*;
(
  input wire         pclk,
  input wire         rst,
  input wire coord_t hcount,
  input wire coord_t vcount,
  input wire rgb_t   rgb_in,
  hole_if.render     hole,
  output rgb_t       rgb_out,
  output coord_t     obstacle_x,
  output coord_t     obstacle_y
);

  logic in_field;
  logic in_wall;

  assign in_field = (hcount >= FIELD_LEFT) && (hcount <= FIELD_RIGHT) &&
                    (vcount >= FIELD_TOP) && (vcount <= FIELD_BOTTOM);

  // everything in the field outside the hole is wall
  assign in_wall = hole.active && in_field &&
                   ((vcount <= hole.pos[EDGE_TOP]) ||
                    (vcount >= hole.pos[EDGE_BOTTOM]) ||
                    (hcount >= hole.pos[EDGE_RIGHT]) ||
                    (hcount <= hole.pos[EDGE_LEFT]));

  always_ff @(posedge pclk) begin
    if (rst) begin
      rgb_out    <= '0;
      obstacle_x <= '0;
      obstacle_y <= '0;
    end else if (in_wall) begin
      rgb_out    <= WALL_RGB;
      obstacle_x <= hcount;  // hit position for collision logic
      obstacle_y <= vcount;
    end else begin
      rgb_out    <= rgb_in;  // pass the background through
      obstacle_x <= '0;
      obstacle_y <= '0;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
source/obstacle_pkg.sv
source/hole_if.sv
source/phase_sequencer.sv
source/hole_edge.sv
source/wall_renderer.sv
source/laser_square_obstacle.sv
bench/tb_clock_gen.sv
bench/tb_laser_square_obstacle.sv
